//--- design/ipic_pkg.sv
//------------------------------
// IPIC shared definitions
// Widths, CSR address map and the layout of the CSR data word
//------------------------------
`default_nettype none

package ipic_pkg;

    localparam int xlen            = 32;  // CSR data width
    localparam int default_irq_num = 16;  // External lines by default
    localparam int mask_w          = 16;  // Line mask view of the CSR word
    localparam int line_w          = 5;   // Line number field of ICSR

    // Privilege field of ICSR, machine mode only
    localparam logic [1:0] prv_machine = 2'd3;

    //------------------------------
    // CSR address map
    //------------------------------
    typedef enum logic [2:0] {
        cisv  = 3'd0,  // Current in-service vector
        cicsr = 3'd1,  // Status of the current vector
        ipr   = 3'd2,  // Aggregated pending
        isvr  = 3'd3,  // Aggregated in service
        eoi   = 3'd4,  // End of interrupt
        soi   = 3'd5,  // Start of interrupt
        idx   = 3'd6,  // Index for ICSR
        icsr  = 3'd7   // Indexed status
    } ipic_addr_e;

    // Per-line status word, LSB field listed last
    typedef struct packed {
        logic [14:0]       rsv_hi;   // 31:17
        logic [line_w-1:0] line;     // 16:12 line number
        logic [1:0]        rsv_mid;  // 11:10
        logic [1:0]        prv;      // 9:8 privilege
        logic [2:0]        rsv_lo;   // 7:5
        logic              is;       // In service
        logic              inv;      // Input inverted
        logic              im;       // Mode, 1 = edge
        logic              ie;       // Enable
        logic              ip;       // Pending
    } ipic_icsr_s;

    // Aggregated register view, one bit per line
    typedef struct packed {
        logic [xlen-mask_w-1:0] rsv;
        logic [mask_w-1:0]      lines;
    } ipic_mask_s;

    // Same CSR word seen as raw, status fields or line mask
    typedef union packed {
        logic [xlen-1:0] raw;
        ipic_icsr_s      icsr;
        ipic_mask_s      mask;
    } ipic_word_u;

endpackage

`default_nettype wire

//--- design/ipic_ctrl_if.sv
//------------------------------
// IPIC control link
// Configuration and strobes from the register block, state back
//------------------------------
`timescale 1ns/1ps
`default_nettype none

interface ipic_ctrl_if #(
    parameter int irq_num = ipic_pkg::default_irq_num
);

    localparam int idx_w  = $clog2(irq_num);  // Line index
    localparam int vect_w = idx_w + 1;        // Top bit marks no vector

    // Register block side
    logic [irq_num-1:0] ier;        // Enables
    logic [irq_num-1:0] imr;        // Modes, 1 = edge
    logic [irq_num-1:0] invr;       // Inversions
    logic [irq_num-1:0] imr_next;   // Modes with this cycle's ICSR write
    logic [irq_num-1:0] invr_next;  // Inversions with this cycle's ICSR write
    logic [irq_num-1:0] ipr_clr;    // Pending clear requests
    logic               soi_wr;     // Start of interrupt strobe
    logic               eoi_wr;     // End of interrupt strobe

    // Datapath side
    logic [irq_num-1:0] ipr;        // Pending
    logic [irq_num-1:0] isvr;       // In service
    logic [vect_w-1:0]  cisv;       // Current vector
    logic               irr_top_vd;   // Some line requested
    logic [idx_w-1:0]   irr_top_idx;  // Winning line

    modport regs (
        output ier, imr, invr, imr_next, invr_next, ipr_clr, soi_wr, eoi_wr,
        input  ipr, isvr, cisv, irr_top_vd, irr_top_idx
    );

    modport datapath (
        input  ier, imr, invr, imr_next, invr_next, ipr_clr, soi_wr, eoi_wr,
        output ipr, isvr, cisv, irr_top_vd, irr_top_idx
    );

endinterface

`default_nettype wire

//--- design/ipic_line_input.sv
//------------------------------
// IPIC line input stage
// Optional 2-flop synchronizer plus previous sample for edges
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module ipic_line_input #(
    parameter int irq_num = ipic_pkg::default_irq_num,
    parameter bit sync_en = 1'b1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [irq_num-1:0] irq_lines,   // Asynchronous lines
    output logic [irq_num-1:0] lines_sync,  // Lines in the clk domain
    output logic [irq_num-1:0] lines_prev   // Last cycle's lines_sync
);

    generate
        if (sync_en) begin : g_sync
            logic [irq_num-1:0] meta;  // First stage, may go metastable

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    meta       <= '0;
                    lines_sync <= '0;
                end else begin
                    meta       <= irq_lines;
                    lines_sync <= meta;  // Two cycles of latency
                end
            end
        end else begin : g_bypass
            // Lines already synchronous to clk
            assign lines_sync = irq_lines;
        end
    endgenerate

    // Edge detect reference
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines_prev <= '0;
        end else begin
            lines_prev <= lines_sync;
        end
    end

endmodule

`default_nettype wire

//--- design/ipic_pending.sv
//------------------------------
// IPIC pending register
// Level lines follow the input, edge lines latch until cleared
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module ipic_pending #(
    parameter int irq_num = ipic_pkg::default_irq_num
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [irq_num-1:0] lines_sync,
    input  logic [irq_num-1:0] lines_prev,
    ipic_ctrl_if.datapath      ctrl
);

    logic [irq_num-1:0] lvl;       // Active level after inversion
    logic [irq_num-1:0] changed;   // Input toggled since last cycle
    logic [irq_num-1:0] ipr_q;
    logic [irq_num-1:0] ipr_next;

    // Inversion written this cycle applies at once
    assign lvl     = lines_sync ^ ctrl.invr_next;
    assign changed = lines_sync ^ lines_prev;

    //------------------------------
    // Next pending state
    //------------------------------
    always_comb begin
        for (int i = 0; i < irq_num; i++) begin
            // Clear loses only to a level line that is still active
            if (ctrl.ipr_clr[i] && (!lvl[i] || ctrl.imr_next[i])) begin
                ipr_next[i] = 1'b0;
            end else if (!ctrl.imr[i]) begin
                ipr_next[i] = lvl[i];                             // Level
            end else begin
                ipr_next[i] = ipr_q[i] | (changed[i] & lvl[i]);   // Edge
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ipr_q <= '0;
        end else begin
            ipr_q <= ipr_next;
        end
    end

    assign ctrl.ipr = ipr_q;

endmodule

`default_nettype wire

//--- design/ipic_priority_enc.sv
//------------------------------
// Lowest-index-first search
// Binary tree of pair stages, combinational
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module ipic_priority_enc #(
    parameter int width = ipic_pkg::default_irq_num  // At least 2
) (
    input  logic [width-1:0]         vec,
    output logic                     found,
    output logic [$clog2(width)-1:0] index
);

    localparam int lvls = $clog2(width);
    localparam int p2   = 1 << lvls;  // Padded to a power of two

    logic [p2-1:0]   vd_st [lvls+1];       // Valid per node and stage
    logic [lvls-1:0] ix_st [lvls+1][p2];   // Index per node and stage

    assign vd_st[0] = p2'(vec);  // Padding bits never win

    generate
        for (genvar n = 0; n < p2; n++) begin : g_leaf
            assign ix_st[0][n] = '0;
        end
        for (genvar s = 1; s <= lvls; s++) begin : g_stage
            for (genvar n = 0; n < p2; n++) begin : g_node
                if (n < (p2 >> s)) begin : g_pair
                    assign vd_st[s][n] = vd_st[s-1][2*n] | vd_st[s-1][2*n+1];
                    // Low half wins, else upper half with bit s-1 set
                    assign ix_st[s][n] = vd_st[s-1][2*n] ? ix_st[s-1][2*n] :
                                         (ix_st[s-1][2*n+1] | lvls'(1 << (s-1)));
                end else begin : g_idle
                    assign vd_st[s][n] = 1'b0;
                    assign ix_st[s][n] = '0;
                end
            end
        end
    endgenerate

    assign found = vd_st[lvls][0];
    assign index = ix_st[lvls][0];

endmodule

`default_nettype wire

//--- design/ipic_service.sv
//------------------------------
// IPIC service tracking
// In-service set, current vector, core request
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module ipic_service #(
    parameter int irq_num = ipic_pkg::default_irq_num
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [irq_num-1:0] ipr,        // Pending set
    output logic               irq_m_req,  // Request to the core
    ipic_ctrl_if.datapath      ctrl
);

    localparam int idx_w  = $clog2(irq_num);
    localparam int vect_w = idx_w + 1;
    localparam logic [vect_w-1:0] void_vect = vect_w'(irq_num);

    logic [irq_num-1:0] irr;        // Pending and enabled
    logic [irq_num-1:0] isvr_q;
    logic [vect_w-1:0]  cisv_q;
    logic [irq_num-1:0] isvr_rest;  // In service minus the current vector
    logic               cand_vd;
    logic [idx_w-1:0]   cand_idx;
    logic               rest_vd;
    logic [idx_w-1:0]   rest_idx;

    assign irr = ipr & ctrl.ier;

    // Next candidate for the core
    ipic_priority_enc #(.width(irq_num)) u_irr_enc (
        .vec   (irr),
        .found (cand_vd),
        .index (cand_idx)
    );

    always_comb begin
        isvr_rest = isvr_q;
        if (!cisv_q[vect_w-1]) begin
            isvr_rest[cisv_q[idx_w-1:0]] = 1'b0;
        end
    end

    // Vector to resume after EOI
    ipic_priority_enc #(.width(irq_num)) u_isv_enc (
        .vec   (isvr_rest),
        .found (rest_vd),
        .index (rest_idx)
    );

    // Candidate must outrank whatever is in service
    assign irq_m_req = cand_vd & (~|isvr_q | ({1'b0, cand_idx} < cisv_q));

    //------------------------------
    // SOI nests, EOI unwinds
    //------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isvr_q <= '0;
            cisv_q <= void_vect;
        end else if (ctrl.soi_wr && irq_m_req) begin
            isvr_q[cand_idx] <= 1'b1;
            cisv_q           <= {1'b0, cand_idx};
        end else if (ctrl.eoi_wr) begin
            isvr_q <= isvr_rest;
            cisv_q <= rest_vd ? {1'b0, rest_idx} : void_vect;  // Void if none left
        end
    end

    assign ctrl.isvr        = isvr_q;
    assign ctrl.cisv        = cisv_q;
    assign ctrl.irr_top_vd  = cand_vd;
    assign ctrl.irr_top_idx = cand_idx;

endmodule

`default_nettype wire

//--- design/ipic_regs.sv
//------------------------------
// IPIC register block
// CSR decode, configuration, clear and SOI/EOI strobes, read mux
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module ipic_regs #(
    parameter int irq_num = ipic_pkg::default_irq_num  // Up to 16 via mask view
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    csr_r_req,
    input  logic                    csr_w_req,
    input  ipic_pkg::ipic_addr_e    csr_addr,
    input  logic [ipic_pkg::xlen-1:0] csr_wdata,
    output logic [ipic_pkg::xlen-1:0] csr_rdata,
    ipic_ctrl_if.regs               ctrl
);

    localparam int idx_w  = $clog2(irq_num);
    localparam int vect_w = idx_w + 1;

    logic [irq_num-1:0]   ier;
    logic [irq_num-1:0]   imr;
    logic [irq_num-1:0]   invr;
    logic [idx_w-1:0]     idxr;      // Selects the line behind ICSR
    logic [irq_num-1:0]   ipr_clr;
    logic                 soi_wr;
    logic                 eoi_wr;
    logic                 wr_icsr;
    logic                 cur_vd;    // A vector is in service
    logic [idx_w-1:0]     cur_idx;
    ipic_pkg::ipic_word_u wr_word;
    ipic_pkg::ipic_word_u rd_word;

    assign wr_word.raw = csr_wdata;
    assign wr_icsr     = csr_w_req && (csr_addr == ipic_pkg::icsr);
    assign cur_vd      = ~ctrl.cisv[vect_w-1];
    assign cur_idx     = ctrl.cisv[idx_w-1:0];

    //------------------------------
    // Configuration registers
    //------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ier  <= '0;
            imr  <= '0;
            invr <= '0;
            idxr <= '0;
        end else if (csr_w_req) begin
            case (csr_addr)
                ipic_pkg::cicsr: begin
                    if (cur_vd) begin
                        ier[cur_idx] <= wr_word.icsr.ie;  // Enable of current vector
                    end
                end
                ipic_pkg::idx:  idxr <= wr_word.raw[idx_w-1:0];
                ipic_pkg::icsr: begin
                    ier[idxr]  <= wr_word.icsr.ie;
                    imr[idxr]  <= wr_word.icsr.im;
                    invr[idxr] <= wr_word.icsr.inv;
                end
                default: ;
            endcase
        end
    end

    // Mode and inversion as seen by the pending logic this cycle
    always_comb begin
        ctrl.imr_next  = imr;
        ctrl.invr_next = invr;
        if (wr_icsr) begin
            ctrl.imr_next[idxr]  = wr_word.icsr.im;
            ctrl.invr_next[idxr] = wr_word.icsr.inv;
        end
    end

    //------------------------------
    // Clear requests and strobes
    //------------------------------
    always_comb begin
        ipr_clr = '0;
        soi_wr  = 1'b0;
        eoi_wr  = 1'b0;
        if (csr_w_req) begin
            case (csr_addr)
                ipic_pkg::cicsr: begin
                    if (cur_vd) begin
                        ipr_clr[cur_idx] = wr_word.icsr.ip;
                    end
                end
                ipic_pkg::ipr: ipr_clr = wr_word.mask.lines[irq_num-1:0];  // By mask
                ipic_pkg::eoi: eoi_wr  = cur_vd;  // Nothing to end if void
                ipic_pkg::soi: begin
                    if (ctrl.irr_top_vd) begin
                        soi_wr                    = 1'b1;
                        ipr_clr[ctrl.irr_top_idx] = 1'b1;  // Candidate taken
                    end
                end
                ipic_pkg::icsr: ipr_clr[idxr] = wr_word.icsr.ip;
                default: ;
            endcase
        end
    end

    //------------------------------
    // Read mux, zero when idle
    //------------------------------
    always_comb begin
        rd_word.raw = '0;
        if (csr_r_req) begin
            case (csr_addr)
                ipic_pkg::cisv:  rd_word.raw[vect_w-1:0] = ctrl.cisv;
                ipic_pkg::cicsr: begin
                    rd_word.icsr.ip = ctrl.ipr[cur_idx] & cur_vd;  // Zero when void
                    rd_word.icsr.ie = ier[cur_idx] & cur_vd;
                end
                ipic_pkg::ipr:   rd_word.raw[irq_num-1:0] = ctrl.ipr;
                ipic_pkg::isvr:  rd_word.raw[irq_num-1:0] = ctrl.isvr;
                ipic_pkg::idx:   rd_word.raw[idx_w-1:0]   = idxr;
                ipic_pkg::icsr: begin
                    rd_word.icsr.ip              = ctrl.ipr[idxr];
                    rd_word.icsr.ie              = ier[idxr];
                    rd_word.icsr.im              = imr[idxr];
                    rd_word.icsr.inv             = invr[idxr];
                    rd_word.icsr.is              = ctrl.isvr[idxr];
                    rd_word.icsr.prv             = ipic_pkg::prv_machine;
                    rd_word.icsr.line[idx_w-1:0] = idxr;
                end
                default: rd_word.raw = '0;  // EOI and SOI read as zero
            endcase
        end
    end

    assign csr_rdata = rd_word.raw;

    assign ctrl.ier     = ier;
    assign ctrl.imr     = imr;
    assign ctrl.invr    = invr;
    assign ctrl.ipr_clr = ipr_clr;
    assign ctrl.soi_wr  = soi_wr;
    assign ctrl.eoi_wr  = eoi_wr;

endmodule

`default_nettype wire

//--- design/ipic_top.sv
//------------------------------
// IPIC top level
// Interrupt controller for the RISC-V core, CSR port and lines
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module ipic_top #(
    parameter int irq_num = ipic_pkg::default_irq_num,
    parameter bit sync_en = 1'b1   // Lines are asynchronous
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [irq_num-1:0]        irq_lines,
    input  logic                      csr_r_req,
    input  logic                      csr_w_req,
    input  ipic_pkg::ipic_addr_e      csr_addr,
    input  logic [ipic_pkg::xlen-1:0] csr_wdata,
    output logic [ipic_pkg::xlen-1:0] csr_rdata,  // Same-cycle read data
    output logic                      irq_m_req   // To the core
);

    logic [irq_num-1:0] lines_sync;
    logic [irq_num-1:0] lines_prev;

    ipic_ctrl_if #(.irq_num(irq_num)) ctrl_if ();

    ipic_line_input #(.irq_num(irq_num), .sync_en(sync_en)) u_line_input (
        .clk        (clk),
        .rst_n      (rst_n),
        .irq_lines  (irq_lines),
        .lines_sync (lines_sync),
        .lines_prev (lines_prev)
    );

    ipic_pending #(.irq_num(irq_num)) u_pending (
        .clk        (clk),
        .rst_n      (rst_n),
        .lines_sync (lines_sync),
        .lines_prev (lines_prev),
        .ctrl       (ctrl_if.datapath)
    );

    ipic_regs #(.irq_num(irq_num)) u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_r_req (csr_r_req),
        .csr_w_req (csr_w_req),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .ctrl      (ctrl_if.regs)
    );

    ipic_service #(.irq_num(irq_num)) u_service (
        .clk       (clk),
        .rst_n     (rst_n),
        .ipr       (ctrl_if.ipr),
        .irq_m_req (irq_m_req),
        .ctrl      (ctrl_if.datapath)
    );

endmodule

`default_nettype wire

//--- tests/ipic_tests.svh
//------------------------------
// IPIC directed tests
// CSR drivers, waits and the test sequences
//------------------------------
`ifndef ipic_tests_svh
`define ipic_tests_svh
`default_nettype none

    // One write, state updates on the next edge
    task automatic csr_write(input ipic_pkg::ipic_addr_e addr,
                             input logic [ipic_pkg::xlen-1:0] data);
        @(posedge clk);
        #2;
        csr_w_req = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(posedge clk);
        #2;
        csr_w_req = 1'b0;
        csr_wdata = '0;
    endtask

    // Same-cycle read, sampled mid cycle
    task automatic csr_read(input ipic_pkg::ipic_addr_e addr,
                            output logic [ipic_pkg::xlen-1:0] data);
        @(posedge clk);
        #2;
        csr_r_req = 1'b1;
        csr_addr  = addr;
        @(negedge clk);
        data = csr_rdata;
        @(posedge clk);
        #2;
        csr_r_req = 1'b0;
    endtask

    task automatic read_expect(input ipic_pkg::ipic_addr_e addr, input string what,
                               input logic [ipic_pkg::xlen-1:0] exp);
        logic [ipic_pkg::xlen-1:0] rd;
        csr_read(addr, rd);
        check_word(what, rd, exp);
    endtask

    // Index then status write
    task automatic config_line(input int n, input logic ie, input logic im, input logic inv);
        ipic_pkg::ipic_word_u w;
        w.raw      = '0;
        w.icsr.ie  = ie;
        w.icsr.im  = im;
        w.icsr.inv = inv;
        csr_write(ipic_pkg::idx, n);
        csr_write(ipic_pkg::icsr, w.raw);
    endtask

    task automatic set_line(input int n, input logic v);
        @(posedge clk);
        #2 irq_lines[n] = v;
    endtask

    task automatic sample_req(input string what, input logic exp);
        @(negedge clk);
        check_bit(what, irq_m_req, exp);
    endtask

    task automatic wait_req(input logic exp, input string what);
        bit done;
        done = 1'b0;
        for (int i = 0; i < req_wait && !done; i++) begin
            @(negedge clk);
            if (irq_m_req === exp) done = 1'b1;
        end
        if (!done) begin
            timeout_count++;
            $display("Timeout: irq_m_req did not go to %b for %s", exp, what);
        end
    endtask

    task automatic wait_ipr_bit(input int n, input logic exp);
        logic [ipic_pkg::xlen-1:0] rd;
        bit done;
        done = 1'b0;
        for (int i = 0; i < req_wait && !done; i++) begin
            csr_read(ipic_pkg::ipr, rd);
            if (rd[n] === exp) done = 1'b1;
        end
        if (!done) begin
            timeout_count++;
            $display("Timeout: pending bit of line %0d did not go to %b", n, exp);
        end
    endtask

    //------------------------------
    // Directed tests
    //------------------------------
    task automatic test_reset_state();
        sample_req("irq_m_req after reset", 1'b0);
        read_expect(ipic_pkg::cisv, "cisv after reset", irq_num);  // Void vector
        read_expect(ipic_pkg::isvr, "isvr after reset", '0);
        read_expect(ipic_pkg::ipr, "ipr after reset", '0);
    endtask

    task automatic test_level();
        int line;
        int other;
        line  = {$random(seed)} % irq_num;
        other = (line + 8) % irq_num;   // Left disabled
        config_line(line, 1'b1, 1'b0, 1'b0);
        set_line(line, 1'b1);
        wait_req(1'b1, "level line raised");
        read_expect(ipic_pkg::ipr, "ipr level set", 32'd1 << line);
        set_line(line, 1'b0);
        wait_req(1'b0, "level line dropped");
        read_expect(ipic_pkg::ipr, "ipr level clear", '0);
        set_line(other, 1'b1);
        wait_ipr_bit(other, 1'b1);
        sample_req("irq_m_req from disabled line", 1'b0);
        set_line(other, 1'b0);
        wait_ipr_bit(other, 1'b0);
    endtask

    task automatic test_edge();
        int line;
        line = {$random(seed)} % irq_num;
        config_line(line, 1'b1, 1'b1, 1'b0);
        set_line(line, 1'b1);
        wait_req(1'b1, "edge line raised");
        set_line(line, 1'b0);
        repeat (4) @(negedge clk);   // Fall passes sync and pending stages
        check_bit("irq_m_req edge latched", irq_m_req, 1'b1);
        read_expect(ipic_pkg::ipr, "ipr edge latched", 32'd1 << line);
        csr_write(ipic_pkg::ipr, 32'd1 << line);   // Clear by mask
        sample_req("irq_m_req after edge clear", 1'b0);
        read_expect(ipic_pkg::ipr, "ipr edge cleared", '0);
    endtask

    task automatic test_inversion();
        int line;
        line = {$random(seed)} % irq_num;
        config_line(line, 1'b1, 1'b0, 1'b1);
        wait_req(1'b1, "inverted line low");
        read_expect(ipic_pkg::ipr, "ipr inverted low", 32'd1 << line);
        set_line(line, 1'b1);
        wait_req(1'b0, "inverted line high");
        read_expect(ipic_pkg::ipr, "ipr inverted high", '0);
        set_line(line, 1'b0);
        wait_req(1'b1, "inverted line low again");
        config_line(line, 1'b0, 1'b0, 1'b0);   // Back to plain level, disabled
        wait_req(1'b0, "inversion removed");
        read_expect(ipic_pkg::ipr, "ipr inversion removed", '0);
    endtask

    task automatic test_nesting();
        config_line(1, 1'b1, 1'b0, 1'b0);
        config_line(3, 1'b1, 1'b0, 1'b0);
        config_line(9, 1'b1, 1'b0, 1'b0);
        set_line(3, 1'b1);
        set_line(9, 1'b1);
        wait_req(1'b1, "lines 3 and 9");
        wait_ipr_bit(9, 1'b1);
        read_expect(ipic_pkg::ipr, "ipr lines 3 and 9", (32'd1 << 3) | (32'd1 << 9));
        csr_write(ipic_pkg::soi, '0);
        sample_req("irq_m_req serving 3", 1'b0);    // 9 ranks below 3
        read_expect(ipic_pkg::cisv, "cisv after first SOI", 32'd3);
        read_expect(ipic_pkg::isvr, "isvr after first SOI", 32'd1 << 3);
        set_line(1, 1'b1);
        wait_req(1'b1, "line 1 preempts");
        csr_write(ipic_pkg::soi, '0);
        sample_req("irq_m_req serving 1", 1'b0);
        read_expect(ipic_pkg::cisv, "cisv nested", 32'd1);
        read_expect(ipic_pkg::isvr, "isvr nested", (32'd1 << 1) | (32'd1 << 3));
        read_expect(ipic_pkg::cicsr, "cicsr of vector 1", 32'h3);  // ip and ie
        set_line(1, 1'b0);
        wait_ipr_bit(1, 1'b0);
        csr_write(ipic_pkg::eoi, '0);
        sample_req("irq_m_req back on 3", 1'b0);
        read_expect(ipic_pkg::cisv, "cisv after first EOI", 32'd3);
        read_expect(ipic_pkg::isvr, "isvr after first EOI", 32'd1 << 3);
        csr_write(ipic_pkg::eoi, '0);
        sample_req("irq_m_req with nothing in service", 1'b1);  // 3 still pending
        read_expect(ipic_pkg::cisv, "cisv after second EOI", irq_num);
        read_expect(ipic_pkg::isvr, "isvr after second EOI", '0);
        set_line(3, 1'b0);
        set_line(9, 1'b0);
        wait_req(1'b0, "lines 3 and 9 dropped");
    endtask

    task automatic test_readback();
        logic [ipic_pkg::xlen-1:0] exp;
        // ie, im, inv, prv machine, line 6
        exp = (32'd1 << 1) | (32'd1 << 2) | (32'd1 << 3) | (32'd3 << 8) | (32'd6 << 12);
        config_line(6, 1'b1, 1'b1, 1'b1);
        // Old mode holds at the write edge, so the inverted low input may set ip
        csr_write(ipic_pkg::ipr, 32'd1 << 6);
        read_expect(ipic_pkg::icsr, "icsr readback", exp);
        read_expect(ipic_pkg::idx, "idx readback", 32'd6);
        read_expect(ipic_pkg::cicsr, "cicsr while void", '0);
        @(posedge clk);
        #2 csr_addr = ipic_pkg::icsr;   // Address set, no read request
        @(negedge clk);
        check_word("rdata while idle", csr_rdata, '0);
    endtask

`default_nettype wire
`endif

//--- tests/ipic_tb.sv
//------------------------------
// IPIC testbench
// Clock, reset, CSR drivers, compare tasks and watchdog
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module ipic_tb;

    localparam int irq_num     = 16;
    localparam int clk_period  = 20;    // ns
    localparam int req_wait    = 5;     // Max cycles for a line to reach irq_m_req
    // Reset 10 + level 80 + edge 60 + inversion 60 + nesting 140 + readback 50
    localparam int test_cycles = 400;

    logic                      clk;
    logic                      rst_n;
    logic [irq_num-1:0]        irq_lines;
    logic                      csr_r_req;
    logic                      csr_w_req;
    ipic_pkg::ipic_addr_e      csr_addr;
    logic [ipic_pkg::xlen-1:0] csr_wdata;
    logic [ipic_pkg::xlen-1:0] csr_rdata;
    logic                      irq_m_req;

    int seed          = 69;  // Line picks
    int check_count   = 0;
    int error_count   = 0;
    int timeout_count = 0;

    ipic_top #(.irq_num(irq_num), .sync_en(1'b1)) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq_lines (irq_lines),
        .csr_r_req (csr_r_req),
        .csr_w_req (csr_w_req),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .irq_m_req (irq_m_req)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    //------------------------------
    // Compare tasks
    //------------------------------
    task automatic check_word(input string what, input logic [ipic_pkg::xlen-1:0] got,
                              input logic [ipic_pkg::xlen-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Safety net if a wait loop or the DUT locks up
    initial begin
        #(5 * test_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, tests did not finish", 5 * test_cycles);
        $display("Regression failed");
        $finish;
    end

    //------------------------------
    // Main sequence
    //------------------------------
    initial begin
        rst_n     = 1'b0;
        irq_lines = '0;
        csr_r_req = 1'b0;
        csr_w_req = 1'b0;
        csr_addr  = ipic_pkg::cisv;
        csr_wdata = '0;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;   // Release off the edge

        test_reset_state();
        test_level();
        test_edge();
        test_inversion();
        test_nesting();
        test_readback();

        $display("Summary: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    `include "ipic_tests.svh"

endmodule

`default_nettype wire

//--- sim.f
+incdir+tests
design/ipic_pkg.sv
design/ipic_ctrl_if.sv
design/ipic_line_input.sv
design/ipic_pending.sv
design/ipic_priority_enc.sv
design/ipic_service.sv
design/ipic_regs.sv
design/ipic_top.sv
tests/ipic_tb.sv

//--- Bender.yml
package:
  name: ipic

sources:
  - files:
      - design/ipic_pkg.sv
      - design/ipic_ctrl_if.sv
      - design/ipic_line_input.sv
      - design/ipic_pending.sv
      - design/ipic_priority_enc.sv
      - design/ipic_service.sv
      - design/ipic_regs.sv
      - design/ipic_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/ipic_tb.sv
